// ==== src/rolly_pkg.sv ====
`default_nettype none

package rolly_pkg;

  localparam int DATA_W   = 16;
  localparam int LG_DEPTH = 3;
  localparam int DEPTH    = 1 << LG_DEPTH;

  typedef logic [DATA_W-1:0]   word_t;
  typedef logic [LG_DEPTH-1:0] addr_t;
  typedef logic [LG_DEPTH:0]   ptr_t;  // MSB is the wrap bit.

  // Consumer control, each field a single-cycle pulse.
  typedef struct packed {
    logic commit;    // Release the oldest sent word.
    logic rollback;  // Replay from the committed pointer.
    logic clear;     // Empty the buffer.
  } rolly_ctrl_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_REQ,
    TX_WAIT_LOW
  } tx_state_t;

  typedef enum logic {
    RX_IDLE,
    RX_ACK
  } rx_state_t;

endpackage

`default_nettype wire

// ==== src/rolly_ptr_tracker.sv ====
`default_nettype none

module rolly_ptr_tracker (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  rolly_pkg::rolly_ctrl_t ctrl_i,
  input  logic                  enq_i,
  input  logic                  deq_i,
  output rolly_pkg::ptr_t       wptr_o,
  output rolly_pkg::ptr_t       rptr_next_o,
  output logic                  full_o,
  output logic                  empty_o
);

  import rolly_pkg::*;

  ptr_t wptr_r, wptr_n;
  ptr_t rptr_r, rptr_n;
  ptr_t cptr_r, cptr_n;
  logic has_uncommitted;

  assign has_uncommitted = (cptr_r != rptr_r);

  always_comb begin
    wptr_n = wptr_r;
    if (ctrl_i.clear) begin
      wptr_n = '0;
    end else if (enq_i) begin
      wptr_n = wptr_r + 1'b1;
    end
  end

  // Commit only moves up to the speculative read pointer.
  always_comb begin
    cptr_n = cptr_r;
    if (ctrl_i.clear) begin
      cptr_n = '0;
    end else if (ctrl_i.commit && has_uncommitted) begin
      cptr_n = cptr_r + 1'b1;
    end
  end

  always_comb begin
    rptr_n = rptr_r;
    if (ctrl_i.clear) begin
      rptr_n = '0;
    end else if (ctrl_i.rollback) begin
      rptr_n = cptr_n;  // Picks up a commit in the same cycle.
    end else if (deq_i) begin
      rptr_n = rptr_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
      cptr_r <= '0;
    end else begin
      wptr_r <= wptr_n;
      rptr_r <= rptr_n;
      cptr_r <= cptr_n;
    end
  end

  assign wptr_o      = wptr_r;
  assign rptr_next_o = rptr_n;

  // Space is only reclaimed by commit, so full looks at the committed pointer.
  assign full_o  = (wptr_r[LG_DEPTH] != cptr_r[LG_DEPTH]) &&
                   (wptr_r[LG_DEPTH-1:0] == cptr_r[LG_DEPTH-1:0]);
  assign empty_o = (rptr_r == wptr_r);

endmodule

`default_nettype wire

// ==== src/rolly_sync_ram.sv ====
`default_nettype none

module rolly_sync_ram (
  input  logic             clk_i,
  input  logic             w_en_i,
  input  rolly_pkg::addr_t w_addr_i,
  input  rolly_pkg::word_t w_data_i,
  input  logic             r_en_i,
  input  rolly_pkg::addr_t r_addr_i,
  output rolly_pkg::word_t r_data_o
);

  import rolly_pkg::*;

  word_t mem [DEPTH];
  word_t r_data_r;

  always_ff @(posedge clk_i) begin
    if (w_en_i) begin
      mem[w_addr_i] <= w_data_i;
    end
  end

  // Read data holds its value while the read port is idle.
  always_ff @(posedge clk_i) begin
    if (r_en_i) begin
      r_data_r <= mem[r_addr_i];
    end
  end

  assign r_data_o = r_data_r;

endmodule

`default_nettype wire

// ==== src/rolly_fifo.sv ====
`default_nettype none

module rolly_fifo (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  rolly_pkg::rolly_ctrl_t ctrl_i,
  input  logic                   enq_v_i,
  input  rolly_pkg::word_t       enq_data_i,
  output logic                   enq_ready_o,
  output logic                   deq_v_o,
  output rolly_pkg::word_t       deq_data_o,
  input  logic                   deq_yumi_i
);

  import rolly_pkg::*;

  ptr_t  wptr;
  ptr_t  rptr_next;
  logic  full;
  logic  empty;
  logic  enq;
  logic  same_addr_n;
  logic  same_addr_r;
  word_t mem_data;
  word_t bypass_r;

  assign enq_ready_o = ~ctrl_i.clear & ~full;
  assign deq_v_o     = ~ctrl_i.clear & ~ctrl_i.rollback & ~empty;
  assign enq         = enq_v_i & enq_ready_o;

  rolly_ptr_tracker i_rolly_ptr_tracker (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ctrl_i      (ctrl_i),
    .enq_i       (enq),
    .deq_i       (deq_yumi_i),
    .wptr_o      (wptr),
    .rptr_next_o (rptr_next),
    .full_o      (full),
    .empty_o     (empty)
  );

  // Write landing on the slot about to be read.
  assign same_addr_n = enq & (wptr == rptr_next);

  rolly_sync_ram i_rolly_sync_ram (
    .clk_i    (clk_i),
    .w_en_i   (enq),
    .w_addr_i (wptr[LG_DEPTH-1:0]),
    .w_data_i (enq_data_i),
    .r_en_i   (~same_addr_n),
    .r_addr_i (rptr_next[LG_DEPTH-1:0]),
    .r_data_o (mem_data)
  );

  always_ff @(posedge clk_i) begin
    if (same_addr_n) begin
      bypass_r <= enq_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      same_addr_r <= 1'b0;
    end else begin
      same_addr_r <= same_addr_n;
    end
  end

  assign deq_data_o = same_addr_r ? bypass_r : mem_data;

endmodule

`default_nettype wire

// ==== src/req_ack_rx.sv ====
`default_nettype none

module req_ack_rx (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_i,
  input  rolly_pkg::word_t data_i,
  output logic             ack_o,
  output logic             enq_v_o,
  output rolly_pkg::word_t enq_data_o,
  input  logic             enq_ready_i
);

  import rolly_pkg::*;

  rx_state_t state_r, state_n;

  // The word is offered straight from the link while the source holds it.
  assign enq_v_o    = (state_r == RX_IDLE) & req_i;
  assign enq_data_o = data_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      RX_IDLE: begin
        if (req_i && enq_ready_i) begin
          state_n = RX_ACK;  // Enqueued at this edge.
        end
      end
      RX_ACK: begin
        if (!req_i) begin
          state_n = RX_IDLE;
        end
      end
      default: begin
        state_n = RX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= RX_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  assign ack_o = (state_r == RX_ACK);

endmodule

`default_nettype wire

// ==== src/req_ack_tx.sv ====
`default_nettype none

module req_ack_tx (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             deq_v_i,
  input  rolly_pkg::word_t deq_data_i,
  output logic             deq_yumi_o,
  output logic             req_o,
  output rolly_pkg::word_t data_o,
  input  logic             ack_i
);

  import rolly_pkg::*;

  tx_state_t state_r, state_n;
  word_t     data_r;

  assign deq_yumi_o = (state_r == TX_IDLE) & deq_v_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      TX_IDLE:     if (deq_v_i) state_n = TX_REQ;
      TX_REQ:      if (ack_i)   state_n = TX_WAIT_LOW;
      TX_WAIT_LOW: if (!ack_i)  state_n = TX_IDLE;  // Sink done, link free.
      default:     state_n = TX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= TX_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  // Held for the whole handshake.
  always_ff @(posedge clk_i) begin
    if (deq_yumi_o) begin
      data_r <= deq_data_i;
    end
  end

  assign req_o  = (state_r == TX_REQ);
  assign data_o = data_r;

endmodule

`default_nettype wire

// ==== src/replay_buffer_top.sv ====
`default_nettype none

module replay_buffer_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  input  rolly_pkg::word_t       data_i,
  output logic                   ack_o,
  output logic                   req_o,
  output rolly_pkg::word_t       data_o,
  input  logic                   ack_i,
  input  rolly_pkg::rolly_ctrl_t ctrl_i
);

  import rolly_pkg::*;

  logic  enq_v;
  logic  enq_ready;
  word_t enq_data;
  logic  deq_v;
  logic  deq_yumi;
  word_t deq_data;

  req_ack_rx i_req_ack_rx (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .data_i      (data_i),
    .ack_o       (ack_o),
    .enq_v_o     (enq_v),
    .enq_data_o  (enq_data),
    .enq_ready_i (enq_ready)
  );

  rolly_fifo i_rolly_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ctrl_i      (ctrl_i),
    .enq_v_i     (enq_v),
    .enq_data_i  (enq_data),
    .enq_ready_o (enq_ready),
    .deq_v_o     (deq_v),
    .deq_data_o  (deq_data),
    .deq_yumi_i  (deq_yumi)
  );

  req_ack_tx i_req_ack_tx (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .deq_v_i    (deq_v),
    .deq_data_i (deq_data),
    .deq_yumi_o (deq_yumi),
    .req_o      (req_o),
    .data_o     (data_o),
    .ack_i      (ack_i)
  );

endmodule

`default_nettype wire

// ==== dv/replay_buffer_checker.sv ====
`default_nettype none

module replay_buffer_checker (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             req_i,
  input rolly_pkg::word_t data_i,
  input logic             ack_o,
  input logic             req_o,
  input rolly_pkg::word_t data_o,
  input logic             ack_i,
  input logic             full_i
);

  // Source side of the input link.
  a_data_i_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i && !ack_o) |=> $stable(data_i))
    else $error("data_i changed while req_i was waiting for ack_o");

  // The source may drop req_i as soon as it sees ack_o.
  a_ack_o_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> $past(req_i))
    else $error("ack_o rose without req_i");

  // Output link.
  a_req_o_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_o && !ack_i) |=> req_o)
    else $error("req_o dropped before ack_i");

  a_data_o_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_o |=> (!req_o || $stable(data_o)))
    else $error("data_o changed during an output handshake");

  // No word is accepted at an edge where the FIFO is full.
  a_no_enq_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    full_i |=> !$rose(ack_o))
    else $error("ack_o rose for a word offered while the FIFO was full");

endmodule

bind replay_buffer_top replay_buffer_checker i_replay_buffer_checker (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .req_i   (req_i),
  .data_i  (data_i),
  .ack_o   (ack_o),
  .req_o   (req_o),
  .data_o  (data_o),
  .ack_i   (ack_i),
  .full_i  (i_rolly_fifo.full)
);

`default_nettype wire

// ==== dv/replay_buffer_tb.sv ====
`default_nettype none

module replay_buffer_tb;

  import rolly_pkg::*;

  localparam int NUM_ROWS     = 16;
  localparam int ROW_CYCLES   = 200;
  localparam int HS_LIMIT     = 64;  // Cycles allowed for one handshake phase.
  localparam int STALL_CYCLES = 30;

  typedef enum logic [1:0] {
    ACT_NONE,
    ACT_COMMIT,
    ACT_ROLLBACK,
    ACT_CLEAR
  } action_e;

  typedef struct packed {
    int      n_push;
    int      n_recv;
    int      stall;     // Last push must wait for a commit.
    action_e action;
    int      n_action;
    int      n_avail;
  } row_t;

  logic        clk_i;
  logic        rst_n_i;
  logic        req_i;
  word_t       data_i;
  logic        ack_o;
  logic        req_o;
  word_t       data_o;
  logic        ack_i;
  rolly_ctrl_t ctrl_i;

  row_t        rows [NUM_ROWS];
  word_t       model_q[$];
  int          commit_idx;
  int          read_idx;
  bit          tx_held;    // Sender holds a word taken from the FIFO.
  word_t       held_val;
  logic [31:0] lcg_state;
  int          pass_count;
  int          fail_count;

  replay_buffer_top i_replay_buffer_top (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req_i),
    .data_i  (data_i),
    .ack_o   (ack_o),
    .req_o   (req_o),
    .data_o  (data_o),
    .ack_i   (ack_i),
    .ctrl_i  (ctrl_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_ack_o(input logic level);
    int n;
    n = 0;
    while (ack_o !== level && n < HS_LIMIT) begin
      next_cycle();
      n++;
    end
    if (ack_o !== level) begin
      fail_count++;
      $display("Input link stuck: ack_o never went to %0b", level);
    end
  endtask

  task automatic wait_req_o(input logic level);
    int n;
    n = 0;
    while (req_o !== level && n < HS_LIMIT) begin
      next_cycle();
      n++;
    end
    if (req_o !== level) begin
      fail_count++;
      $display("Output link stuck: req_o never went to %0b", level);
    end
  endtask

  task automatic apply_action(input action_e act, input int n);
    rolly_ctrl_t pulse;
    int          reps;
    pulse = '0;
    case (act)
      ACT_COMMIT:   pulse.commit = 1'b1;
      ACT_ROLLBACK: pulse.rollback = 1'b1;
      ACT_CLEAR:    pulse.clear = 1'b1;
      default:      pulse = '0;
    endcase
    reps = (act == ACT_COMMIT) ? n : ((act == ACT_NONE) ? 0 : 1);
    for (int k = 0; k < reps; k++) begin
      ctrl_i = pulse;
      next_cycle();
      ctrl_i = '0;
      next_cycle();
      if (act == ACT_COMMIT && commit_idx < read_idx) begin
        commit_idx++;  // Commit is dropped when nothing is outstanding.
      end else if (act == ACT_ROLLBACK) begin
        read_idx = commit_idx;
      end else if (act == ACT_CLEAR) begin
        model_q.delete();
        commit_idx = 0;
        read_idx   = 0;
      end
    end
  endtask

  task automatic push_word(input word_t val);
    data_i = val;
    req_i  = 1'b1;
    wait_ack_o(1'b1);
    req_i = 1'b0;
    wait_ack_o(1'b0);
    model_q.push_back(val);
  endtask

  task automatic push_blocked(input word_t val);
    int seen;
    seen   = 0;
    data_i = val;
    req_i  = 1'b1;
    repeat (STALL_CYCLES) begin
      next_cycle();
      if (ack_o) seen = 1;
    end
    check_value("ack_o while full", seen, 0);
    apply_action(ACT_COMMIT, 1);  // One freed slot lets the word in.
    wait_ack_o(1'b1);
    req_i = 1'b0;
    wait_ack_o(1'b0);
    model_q.push_back(val);
  endtask

  task automatic recv_word();
    word_t       exp;
    logic [31:0] r;
    int          wait_n;
    wait_req_o(1'b1);
    if (tx_held) begin
      exp     = held_val;
      tx_held = 1'b0;
    end else if (read_idx < model_q.size()) begin
      exp = model_q[read_idx];
      read_idx++;
    end else begin
      exp = '0;
      fail_count++;
      $display("Reference model has no word left to deliver");
    end
    check_value("data_o", 32'(data_o), 32'(exp));
    r      = lcg_next();
    wait_n = int'(r[31:30]);
    repeat (wait_n) next_cycle();
    ack_i = 1'b1;
    wait_req_o(1'b0);
    ack_i = 1'b0;
  endtask

  // An idle sender grabs the next word a cycle after it shows up.
  task automatic settle_model();
    repeat (4) next_cycle();
    if (!tx_held && read_idx < model_q.size()) begin
      tx_held  = 1'b1;
      held_val = model_q[read_idx];
      read_idx++;
    end
  endtask

  task automatic run_row(input int idx, input row_t row);
    int    fails_before;
    int    avail;
    logic [31:0] r;
    fails_before = fail_count;
    for (int k = 0; k < row.n_push - row.stall; k++) begin
      r = lcg_next();
      push_word(r[31:16]);
    end
    for (int k = 0; k < row.n_recv; k++) begin
      recv_word();
    end
    settle_model();
    if (row.stall != 0) begin
      r = lcg_next();
      push_blocked(r[31:16]);
      settle_model();
    end
    apply_action(row.action, row.n_action);
    settle_model();
    avail = int'(tx_held) + model_q.size() - read_idx;
    check_value("words available", avail, row.n_avail);
    check_value("req_o", 32'(req_o), 32'(tx_held));
    $display("row %0d push %0d recv %0d %s: %s", idx, row.n_push, row.n_recv,
             row.action.name(), (fail_count == fails_before) ? "ok" : "mismatch");
  endtask

  task automatic load_table();
    rows[0]  = '{4, 2, 0, ACT_NONE, 0, 2};      // Streaming with commits.
    rows[1]  = '{2, 3, 0, ACT_COMMIT, 3, 1};
    rows[2]  = '{3, 4, 0, ACT_COMMIT, 6, 0};
    rows[3]  = '{3, 3, 0, ACT_ROLLBACK, 1, 3};  // Full replay.
    rows[4]  = '{0, 3, 0, ACT_COMMIT, 3, 0};
    rows[5]  = '{5, 5, 0, ACT_COMMIT, 2, 0};    // Partial commit.
    rows[6]  = '{0, 0, 0, ACT_ROLLBACK, 1, 3};
    rows[7]  = '{0, 3, 0, ACT_COMMIT, 3, 0};
    rows[8]  = '{9, 8, 1, ACT_NONE, 0, 1};      // Back-pressure.
    rows[9]  = '{0, 1, 0, ACT_COMMIT, 8, 0};
    rows[10] = '{3, 0, 0, ACT_CLEAR, 1, 1};
    rows[11] = '{2, 3, 0, ACT_COMMIT, 2, 0};
    rows[12] = '{1, 1, 0, ACT_COMMIT, 1, 0};    // Bypass path.
    rows[13] = '{1, 1, 0, ACT_COMMIT, 1, 0};
    rows[14] = '{1, 1, 0, ACT_COMMIT, 1, 0};
    rows[15] = '{1, 1, 0, ACT_COMMIT, 1, 0};
  endtask

  initial begin
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    data_i     = '0;
    ack_i      = 1'b0;
    ctrl_i     = '0;
    lcg_state  = 32'd30611;
    commit_idx = 0;
    read_idx   = 0;
    tx_held    = 1'b0;
    held_val   = '0;
    pass_count = 0;
    fail_count = 0;
    load_table();
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    next_cycle();
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i, rows[i]);
    end
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (NUM_ROWS * ROW_CYCLES + 8) @(posedge clk_i);
    $display("Watchdog expired: the table did not complete in %0d cycles",
             NUM_ROWS * ROW_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
src/rolly_pkg.sv
src/rolly_ptr_tracker.sv
src/rolly_sync_ram.sv
src/rolly_fifo.sv
src/req_ack_rx.sv
src/req_ack_tx.sv
src/replay_buffer_top.sv
dv/replay_buffer_checker.sv
dv/replay_buffer_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the replay buffer testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f project.f \
  --top-module replay_buffer_tb \
  -Mdir "$BUILD_DIR" -o replay_buffer_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/replay_buffer_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
